// ==== core_mem_macros.svh ====
`ifndef CORE_MEM_MACROS_SVH
`define CORE_MEM_MACROS_SVH

// Word, address and byte lane widths
`define CM_DATA_W       32
`define CM_ADDR_W       32
`define CM_BE_W         4

// 256 words per bank, indexed by byte address bits 9:2
`define CM_WORD_ADDR_W  8

// Bank 0 holds instructions, bank 1 holds data
`define CM_NUM_BANKS    2
`define CM_INSTR_BANK   0
`define CM_DATA_BANK    1

// Address bits 31:20 of the data window
`define CM_DATA_REGION  12'h001
`define CM_EXT_CREDITS  2

`endif

// ==== core_mem_pkg.sv ====
`default_nettype none

package core_mem_pkg;

`include "core_mem_macros.svh"

  // Byte address and data word
  typedef logic [`CM_ADDR_W-1:0]      addr_t;
  typedef logic [`CM_DATA_W-1:0]      data_t;
  typedef logic [`CM_BE_W-1:0]        be_t;

  // Word index inside one bank
  typedef logic [`CM_WORD_ADDR_W-1:0] word_addr_t;

  typedef logic [$clog2(`CM_NUM_BANKS)-1:0] bank_sel_t;

  // Wide enough for the external credit pool
  typedef logic [$clog2(`CM_EXT_CREDITS+1)-1:0] credit_t;

  // Source of the load/store responses in flight
  typedef enum logic
  {
    SRC_EXT,
    SRC_RAM
  } lsu_src_t;

endpackage

`default_nettype wire

// ==== req_router.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_macros.svh"

module req_router
(
  input  wire                             clk,
  input  wire                             rst_n,
  // Fetch and load/store requests
  input  wire                             fetch_req_i,
  input  wire  core_mem_pkg::addr_t       fetch_addr_i,
  input  wire                             lsu_req_i,
  input  wire  core_mem_pkg::addr_t       lsu_addr_i,
  input  wire                             lsu_we_i,
  input  wire  core_mem_pkg::be_t         lsu_be_i,
  input  wire  core_mem_pkg::data_t       lsu_wdata_i,
  // Loader requests
  input  wire                             ld_req_i,
  input  wire  core_mem_pkg::bank_sel_t   ld_bank_i,
  input  wire  core_mem_pkg::word_addr_t  ld_addr_i,
  input  wire                             ld_we_i,
  input  wire  core_mem_pkg::be_t         ld_be_i,
  input  wire  core_mem_pkg::data_t       ld_wdata_i,
  // Bank side
  input  wire                             bank_gnt_i    [`CM_NUM_BANKS],
  output logic                            bank_req_o    [`CM_NUM_BANKS],
  output core_mem_pkg::word_addr_t        bank_addr_o   [`CM_NUM_BANKS],
  output logic                            bank_we_o     [`CM_NUM_BANKS],
  output core_mem_pkg::be_t               bank_be_o     [`CM_NUM_BANKS],
  output core_mem_pkg::data_t             bank_wdata_o  [`CM_NUM_BANKS],
  output logic                            bank_ld_req_o [`CM_NUM_BANKS],
  output core_mem_pkg::word_addr_t        ld_addr_o,
  output logic                            ld_we_o,
  output core_mem_pkg::be_t               ld_be_o,
  output core_mem_pkg::data_t             ld_wdata_o,
  // Grants and issue report
  output logic                            fetch_gnt_o,
  output logic                            lsu_gnt_o,
  output logic                            lsu_issue_o,
  output core_mem_pkg::lsu_src_t          lsu_issue_src_o,
  input  wire                             pend_any_i,
  input  wire  core_mem_pkg::lsu_src_t    pend_src_i,
  // External request port
  output logic                            ext_req_o,
  output core_mem_pkg::addr_t             ext_addr_o,
  output logic                            ext_we_o,
  output core_mem_pkg::be_t               ext_be_o,
  output core_mem_pkg::data_t             ext_wdata_o,
  input  wire                             ext_credit_i
);

  import core_mem_pkg::*;

  logic    in_window;
  logic    ram_blocked;
  logic    ext_blocked;
  logic    ext_gnt;
  credit_t credit_q;
  credit_t credit_d;

  assign in_window   = (lsu_addr_i[`CM_ADDR_W-1:20] == `CM_DATA_REGION);
  // Responses of the other source must drain before switching
  assign ram_blocked = pend_any_i && (pend_src_i == SRC_EXT);
  assign ext_blocked = pend_any_i && (pend_src_i == SRC_RAM);
  assign ext_gnt     = lsu_req_i && !in_window && !ext_blocked && (credit_q != '0);

  always_comb
  begin
    for (int b = 0; b < `CM_NUM_BANKS; b++)
    begin
      bank_ld_req_o[b] = ld_req_i && (ld_bank_i == bank_sel_t'(b));
    end

    // Fetch is a full-word read of the instruction bank
    bank_req_o[`CM_INSTR_BANK]   = fetch_req_i;
    bank_addr_o[`CM_INSTR_BANK]  = fetch_addr_i[`CM_WORD_ADDR_W+1:2];
    bank_we_o[`CM_INSTR_BANK]    = 1'b0;
    bank_be_o[`CM_INSTR_BANK]    = '1;
    bank_wdata_o[`CM_INSTR_BANK] = '0;

    bank_req_o[`CM_DATA_BANK]    = lsu_req_i && in_window && !ram_blocked;
    bank_addr_o[`CM_DATA_BANK]   = lsu_addr_i[`CM_WORD_ADDR_W+1:2];
    bank_we_o[`CM_DATA_BANK]     = lsu_we_i;
    bank_be_o[`CM_DATA_BANK]     = lsu_be_i;
    bank_wdata_o[`CM_DATA_BANK]  = lsu_wdata_i;
  end

  // Loader fields are common to all banks
  assign ld_addr_o  = ld_addr_i;
  assign ld_we_o    = ld_we_i;
  assign ld_be_o    = ld_be_i;
  assign ld_wdata_o = ld_wdata_i;

  assign fetch_gnt_o     = bank_gnt_i[`CM_INSTR_BANK];
  assign lsu_gnt_o       = in_window ? bank_gnt_i[`CM_DATA_BANK] : ext_gnt;
  assign lsu_issue_o     = lsu_gnt_o;
  assign lsu_issue_src_o = in_window ? SRC_RAM : SRC_EXT;

  always_comb
  begin
    credit_d = credit_q;
    if (ext_gnt && !ext_credit_i)
      credit_d = credit_q - 1'b1;
    else if (!ext_gnt && ext_credit_i)
      credit_d = credit_q + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      credit_q  <= credit_t'(`CM_EXT_CREDITS);
      ext_req_o <= 1'b0;
    end
    else
    begin
      credit_q  <= credit_d;
      ext_req_o <= ext_gnt;
    end
  end

  // External payload launched with the request pulse
  always_ff @(posedge clk)
  begin
    if (ext_gnt)
    begin
      ext_addr_o  <= lsu_addr_i;
      ext_we_o    <= lsu_we_i;
      ext_be_o    <= lsu_be_i;
      ext_wdata_o <= lsu_wdata_i;
    end
  end

  // The outside returns no more credits than were issued
  credit_bound_a : assert property (@(posedge clk) disable iff (!rst_n)
    credit_q <= credit_t'(`CM_EXT_CREDITS));

endmodule

`default_nettype wire

// ==== mem_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_macros.svh"

module mem_bank
(
  input  wire                             clk,
  input  wire                             rst_n,
  // Requester port
  input  wire                             req_i,
  input  wire  core_mem_pkg::word_addr_t  addr_i,
  input  wire                             we_i,
  input  wire  core_mem_pkg::be_t         be_i,
  input  wire  core_mem_pkg::data_t       wdata_i,
  output logic                            gnt_o,
  output logic                            rvalid_o,
  output core_mem_pkg::data_t             rdata_o,
  // Loader port, wins every conflict
  input  wire                             ld_req_i,
  input  wire  core_mem_pkg::word_addr_t  ld_addr_i,
  input  wire                             ld_we_i,
  input  wire  core_mem_pkg::be_t         ld_be_i,
  input  wire  core_mem_pkg::data_t       ld_wdata_i,
  output logic                            ld_rvalid_o,
  output core_mem_pkg::data_t             ld_rdata_o
);

  import core_mem_pkg::*;

  localparam int NUM_WORDS = 2 ** `CM_WORD_ADDR_W;
  localparam int BYTE_W    = `CM_DATA_W / `CM_BE_W;

  logic       ram_en;
  word_addr_t ram_addr;
  logic       ram_we;
  be_t        ram_be;
  data_t      ram_wdata;
  data_t      ram_rdata_q;
  data_t      mem [NUM_WORDS];
  // Which port owns the word read in the previous cycle
  logic       req_owner_q;
  logic       ld_owner_q;

  assign gnt_o  = req_i && !ld_req_i;
  assign ram_en = req_i || ld_req_i;

  always_comb
  begin
    if (ld_req_i)
    begin
      ram_addr  = ld_addr_i;
      ram_we    = ld_we_i;
      ram_be    = ld_be_i;
      ram_wdata = ld_wdata_i;
    end
    else
    begin
      ram_addr  = addr_i;
      ram_we    = we_i;
      ram_be    = be_i;
      ram_wdata = wdata_i;
    end
  end

  // Read returns the old word, also on a write
  always_ff @(posedge clk)
  begin
    if (ram_en)
    begin
      for (int i = 0; i < `CM_BE_W; i++)
      begin
        if (ram_we && ram_be[i])
        begin
          mem[ram_addr][BYTE_W*i +: BYTE_W] <= ram_wdata[BYTE_W*i +: BYTE_W];
        end
      end
      ram_rdata_q <= mem[ram_addr];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_owner_q <= 1'b0;
      ld_owner_q  <= 1'b0;
    end
    else
    begin
      req_owner_q <= gnt_o;
      ld_owner_q  <= ld_req_i;
    end
  end

  assign rvalid_o    = req_owner_q;
  assign rdata_o     = ram_rdata_q;
  assign ld_rvalid_o = ld_owner_q;
  assign ld_rdata_o  = ram_rdata_q;

  // An ungranted request waits while the loader holds the bank
  req_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    req_i && !gnt_o |=> req_i);

endmodule

`default_nettype wire

// ==== resp_steer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_macros.svh"

module resp_steer
(
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           lsu_issue_i,
  input  wire  core_mem_pkg::lsu_src_t  lsu_issue_src_i,
  // Bank responses
  input  wire                           bank_rvalid_i    [`CM_NUM_BANKS],
  input  wire  core_mem_pkg::data_t     bank_rdata_i     [`CM_NUM_BANKS],
  input  wire                           bank_ld_rvalid_i [`CM_NUM_BANKS],
  input  wire  core_mem_pkg::data_t     bank_ld_rdata_i  [`CM_NUM_BANKS],
  // External responses
  input  wire                           ext_rvalid_i,
  input  wire  core_mem_pkg::data_t     ext_rdata_i,
  // Pending state back to the router
  output logic                          pend_any_o,
  output core_mem_pkg::lsu_src_t        pend_src_o,
  // Requester responses
  output logic                          fetch_rvalid_o,
  output core_mem_pkg::data_t           fetch_rdata_o,
  output logic                          lsu_rvalid_o,
  output core_mem_pkg::data_t           lsu_rdata_o,
  output logic                          ld_rvalid_o,
  output core_mem_pkg::data_t           ld_rdata_o
);

  import core_mem_pkg::*;

  lsu_src_t cs;
  lsu_src_t ns;
  // Bounded by the credit pool, so the credit width is enough
  credit_t  pend_cnt_q;
  credit_t  pend_cnt_d;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cs         <= SRC_RAM;
      pend_cnt_q <= '0;
    end
    else
    begin
      cs         <= ns;
      pend_cnt_q <= pend_cnt_d;
    end
  end

  // Next responses come from the source of the latest issue
  always_comb
  begin
    ns = cs;
    if (lsu_issue_i)
      ns = lsu_issue_src_i;
  end

  always_comb
  begin
    pend_cnt_d = pend_cnt_q;
    if (lsu_issue_i && !lsu_rvalid_o)
      pend_cnt_d = pend_cnt_q + 1'b1;
    else if (!lsu_issue_i && lsu_rvalid_o)
      pend_cnt_d = pend_cnt_q - 1'b1;
  end

  assign pend_any_o = (pend_cnt_q != '0);
  assign pend_src_o = cs;

  always_comb
  begin
    case (cs)
      SRC_EXT:
      begin
        lsu_rvalid_o = ext_rvalid_i;
        lsu_rdata_o  = ext_rdata_i;
      end
      default:
      begin
        lsu_rvalid_o = bank_rvalid_i[`CM_DATA_BANK];
        lsu_rdata_o  = bank_rdata_i[`CM_DATA_BANK];
      end
    endcase
  end

  assign fetch_rvalid_o = bank_rvalid_i[`CM_INSTR_BANK];
  assign fetch_rdata_o  = bank_rdata_i[`CM_INSTR_BANK];

  // Only one bank answers the loader in a given cycle
  always_comb
  begin
    ld_rvalid_o = 1'b0;
    ld_rdata_o  = '0;
    for (int b = 0; b < `CM_NUM_BANKS; b++)
    begin
      if (bank_ld_rvalid_i[b])
      begin
        ld_rvalid_o = 1'b1;
        ld_rdata_o  = bank_ld_rdata_i[b];
      end
    end
  end

  ext_expected_a : assert property (@(posedge clk) disable iff (!rst_n)
    ext_rvalid_i |-> (pend_cnt_q != '0) && (cs == SRC_EXT));

endmodule

`default_nettype wire

// ==== core_mem_region.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_macros.svh"

module core_mem_region
(
  input  wire                             clk,
  input  wire                             rst_n,
  // Fetch port
  input  wire                             fetch_req_i,
  input  wire  core_mem_pkg::addr_t       fetch_addr_i,
  output logic                            fetch_gnt_o,
  output logic                            fetch_rvalid_o,
  output core_mem_pkg::data_t             fetch_rdata_o,
  // Load/store port
  input  wire                             lsu_req_i,
  input  wire  core_mem_pkg::addr_t       lsu_addr_i,
  input  wire                             lsu_we_i,
  input  wire  core_mem_pkg::be_t         lsu_be_i,
  input  wire  core_mem_pkg::data_t       lsu_wdata_i,
  output logic                            lsu_gnt_o,
  output logic                            lsu_rvalid_o,
  output core_mem_pkg::data_t             lsu_rdata_o,
  // Loader port
  input  wire                             ld_req_i,
  input  wire  core_mem_pkg::bank_sel_t   ld_bank_i,
  input  wire  core_mem_pkg::word_addr_t  ld_addr_i,
  input  wire                             ld_we_i,
  input  wire  core_mem_pkg::be_t         ld_be_i,
  input  wire  core_mem_pkg::data_t       ld_wdata_i,
  output logic                            ld_rvalid_o,
  output core_mem_pkg::data_t             ld_rdata_o,
  // External request port
  output logic                            ext_req_o,
  output core_mem_pkg::addr_t             ext_addr_o,
  output logic                            ext_we_o,
  output core_mem_pkg::be_t               ext_be_o,
  output core_mem_pkg::data_t             ext_wdata_o,
  input  wire                             ext_rvalid_i,
  input  wire  core_mem_pkg::data_t       ext_rdata_i,
  input  wire                             ext_credit_i
);

  import core_mem_pkg::*;

  // Router to banks
  logic       bank_req      [`CM_NUM_BANKS];
  word_addr_t bank_addr     [`CM_NUM_BANKS];
  logic       bank_we       [`CM_NUM_BANKS];
  be_t        bank_be       [`CM_NUM_BANKS];
  data_t      bank_wdata    [`CM_NUM_BANKS];
  logic       bank_ld_req   [`CM_NUM_BANKS];
  word_addr_t ld_addr;
  logic       ld_we;
  be_t        ld_be;
  data_t      ld_wdata;
  // Banks to router and steering
  logic       bank_gnt      [`CM_NUM_BANKS];
  logic       bank_rvalid   [`CM_NUM_BANKS];
  data_t      bank_rdata    [`CM_NUM_BANKS];
  logic       bank_ld_rvalid [`CM_NUM_BANKS];
  data_t      bank_ld_rdata [`CM_NUM_BANKS];
  // Router and steering handshake
  logic       lsu_issue;
  lsu_src_t   lsu_issue_src;
  logic       pend_any;
  lsu_src_t   pend_src;

  req_router req_router_inst
  (
    .clk             ( clk           ),
    .rst_n           ( rst_n         ),
    .fetch_req_i     ( fetch_req_i   ),
    .fetch_addr_i    ( fetch_addr_i  ),
    .lsu_req_i       ( lsu_req_i     ),
    .lsu_addr_i      ( lsu_addr_i    ),
    .lsu_we_i        ( lsu_we_i      ),
    .lsu_be_i        ( lsu_be_i      ),
    .lsu_wdata_i     ( lsu_wdata_i   ),
    .ld_req_i        ( ld_req_i      ),
    .ld_bank_i       ( ld_bank_i     ),
    .ld_addr_i       ( ld_addr_i     ),
    .ld_we_i         ( ld_we_i       ),
    .ld_be_i         ( ld_be_i       ),
    .ld_wdata_i      ( ld_wdata_i    ),
    .bank_gnt_i      ( bank_gnt      ),
    .bank_req_o      ( bank_req      ),
    .bank_addr_o     ( bank_addr     ),
    .bank_we_o       ( bank_we       ),
    .bank_be_o       ( bank_be       ),
    .bank_wdata_o    ( bank_wdata    ),
    .bank_ld_req_o   ( bank_ld_req   ),
    .ld_addr_o       ( ld_addr       ),
    .ld_we_o         ( ld_we         ),
    .ld_be_o         ( ld_be         ),
    .ld_wdata_o      ( ld_wdata      ),
    .fetch_gnt_o     ( fetch_gnt_o   ),
    .lsu_gnt_o       ( lsu_gnt_o     ),
    .lsu_issue_o     ( lsu_issue     ),
    .lsu_issue_src_o ( lsu_issue_src ),
    .pend_any_i      ( pend_any      ),
    .pend_src_i      ( pend_src      ),
    .ext_req_o       ( ext_req_o     ),
    .ext_addr_o      ( ext_addr_o    ),
    .ext_we_o        ( ext_we_o      ),
    .ext_be_o        ( ext_be_o      ),
    .ext_wdata_o     ( ext_wdata_o   ),
    .ext_credit_i    ( ext_credit_i  )
  );

  // Bank 0 instructions, bank 1 data
  for (genvar g = 0; g < `CM_NUM_BANKS; g++)
  begin : gen_bank
    mem_bank mem_bank_inst
    (
      .clk         ( clk               ),
      .rst_n       ( rst_n             ),
      .req_i       ( bank_req[g]       ),
      .addr_i      ( bank_addr[g]      ),
      .we_i        ( bank_we[g]        ),
      .be_i        ( bank_be[g]        ),
      .wdata_i     ( bank_wdata[g]     ),
      .gnt_o       ( bank_gnt[g]       ),
      .rvalid_o    ( bank_rvalid[g]    ),
      .rdata_o     ( bank_rdata[g]     ),
      .ld_req_i    ( bank_ld_req[g]    ),
      .ld_addr_i   ( ld_addr           ),
      .ld_we_i     ( ld_we             ),
      .ld_be_i     ( ld_be             ),
      .ld_wdata_i  ( ld_wdata          ),
      .ld_rvalid_o ( bank_ld_rvalid[g] ),
      .ld_rdata_o  ( bank_ld_rdata[g]  )
    );
  end

  resp_steer resp_steer_inst
  (
    .clk              ( clk            ),
    .rst_n            ( rst_n          ),
    .lsu_issue_i      ( lsu_issue      ),
    .lsu_issue_src_i  ( lsu_issue_src  ),
    .bank_rvalid_i    ( bank_rvalid    ),
    .bank_rdata_i     ( bank_rdata     ),
    .bank_ld_rvalid_i ( bank_ld_rvalid ),
    .bank_ld_rdata_i  ( bank_ld_rdata  ),
    .ext_rvalid_i     ( ext_rvalid_i   ),
    .ext_rdata_i      ( ext_rdata_i    ),
    .pend_any_o       ( pend_any       ),
    .pend_src_o       ( pend_src       ),
    .fetch_rvalid_o   ( fetch_rvalid_o ),
    .fetch_rdata_o    ( fetch_rdata_o  ),
    .lsu_rvalid_o     ( lsu_rvalid_o   ),
    .lsu_rdata_o      ( lsu_rdata_o    ),
    .ld_rvalid_o      ( ld_rvalid_o    ),
    .ld_rdata_o       ( ld_rdata_o     )
  );

endmodule

`default_nettype wire

// ==== core_mem_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_mem_macros.svh"

module core_mem_checker
(
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        fetch_gnt_o,
  input  wire                        fetch_rvalid_o,
  input  wire  core_mem_pkg::data_t  fetch_rdata_o,
  input  wire                        lsu_gnt_o,
  input  wire                        lsu_rvalid_o,
  input  wire  core_mem_pkg::data_t  lsu_rdata_o,
  input  wire                        ld_rvalid_o,
  input  wire  core_mem_pkg::data_t  ld_rdata_o,
  input  wire                        ext_req_o,
  input  wire  core_mem_pkg::addr_t  ext_addr_o,
  input  wire                        ext_we_o,
  input  wire  core_mem_pkg::be_t    ext_be_o,
  input  wire  core_mem_pkg::data_t  ext_wdata_o,
  input  wire                        ext_rvalid_i
);

  import core_mem_pkg::*;

  // Expected responses per port, in issue order
  string  ld_name[$];
  data_t  ld_exp[$];
  logic   ld_chk[$];
  string  fetch_name[$];
  data_t  fetch_exp[$];
  logic   fetch_chk[$];
  string  lsu_name[$];
  data_t  lsu_exp[$];
  logic   lsu_chk[$];
  // Expected external request fields
  string  ext_name[$];
  addr_t  ext_addr_q[$];
  logic   ext_we_q[$];
  be_t    ext_be_q[$];
  data_t  ext_wdata_q[$];
  int     ext_pend = 0;
  int     data_errs = 0;
  int     proto_errs = 0;

  task automatic value_check(input string name, input data_t exp, input logic chk,
                             input data_t act);
    if (chk && (act !== exp))
    begin
      data_errs++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic protocol_error(input string msg);
    proto_errs++;
    $display("Protocol error at %0t: %s", $time, msg);
  endtask

  task automatic expect_ld(input string name, input data_t exp, input logic chk);
    ld_name.push_back(name);
    ld_exp.push_back(exp);
    ld_chk.push_back(chk);
  endtask

  task automatic expect_fetch(input string name, input data_t exp, input logic chk);
    fetch_name.push_back(name);
    fetch_exp.push_back(exp);
    fetch_chk.push_back(chk);
  endtask

  task automatic expect_lsu(input string name, input addr_t addr, input logic we,
                            input be_t be, input data_t wdata, input data_t exp,
                            input logic chk);
    lsu_name.push_back(name);
    lsu_exp.push_back(exp);
    lsu_chk.push_back(chk);
    if (addr[31:20] == `CM_DATA_REGION)
    begin
      if (ext_pend != 0)
        protocol_error({name, " granted while external responses were pending"});
    end
    else
    begin
      ext_name.push_back(name);
      ext_addr_q.push_back(addr);
      ext_we_q.push_back(we);
      ext_be_q.push_back(be);
      ext_wdata_q.push_back(wdata);
      ext_pend++;
      if (ext_pend > `CM_EXT_CREDITS)
        protocol_error({name, " granted with no external credit left"});
    end
  endtask

  function automatic int outstanding();
    return ld_name.size() + fetch_name.size() + lsu_name.size() + ext_name.size();
  endfunction

  always @(posedge clk)
  begin : watch_b
    string n;
    logic  we;
    if (!rst_n)
    begin
      if (fetch_gnt_o || fetch_rvalid_o || lsu_gnt_o || lsu_rvalid_o || ld_rvalid_o ||
          ext_req_o)
        protocol_error("handshake output high during reset");
    end
    else
    begin
      if (fetch_rvalid_o && fetch_name.size() == 0)
        protocol_error("fetch response without a granted fetch");
      else if (fetch_rvalid_o)
        value_check(fetch_name.pop_front(), fetch_exp.pop_front(), fetch_chk.pop_front(),
                    fetch_rdata_o);
      if (ld_rvalid_o && ld_name.size() == 0)
        protocol_error("loader response without a loader request");
      else if (ld_rvalid_o)
        value_check(ld_name.pop_front(), ld_exp.pop_front(), ld_chk.pop_front(), ld_rdata_o);
      if (lsu_rvalid_o && lsu_name.size() == 0)
        protocol_error("load/store response without a granted request");
      else if (lsu_rvalid_o)
        value_check(lsu_name.pop_front(), lsu_exp.pop_front(), lsu_chk.pop_front(),
                    lsu_rdata_o);
      if (ext_req_o && ext_name.size() == 0)
        protocol_error("external request without a granted external access");
      else if (ext_req_o)
      begin
        n  = ext_name.pop_front();
        we = ext_we_q.pop_front();
        value_check({n, " ext_addr"}, ext_addr_q.pop_front(), 1'b1, ext_addr_o);
        value_check({n, " ext_we"}, data_t'(we), 1'b1, data_t'(ext_we_o));
        value_check({n, " ext_be"}, data_t'(ext_be_q.pop_front()), 1'b1,
                    data_t'(ext_be_o));
        value_check({n, " ext_wdata"}, ext_wdata_q.pop_front(), we, ext_wdata_o);
      end
      if (ext_rvalid_i)
        ext_pend--;
    end
  end

endmodule

`default_nettype wire

// ==== tb_core_mem_region.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_core_mem_region;

  import core_mem_pkg::*;

  localparam int P_LD      = 0;
  localparam int P_FETCH   = 1;
  localparam int P_LSU     = 2;
  localparam int P_LDFETCH = 3;
  localparam int MAX_ENTRIES = 32;

  logic clk;
  logic rst_n;
  logic fetch_req_i, fetch_gnt_o, fetch_rvalid_o;
  addr_t fetch_addr_i;
  data_t fetch_rdata_o;
  logic lsu_req_i, lsu_we_i, lsu_gnt_o, lsu_rvalid_o;
  addr_t lsu_addr_i;
  be_t lsu_be_i;
  data_t lsu_wdata_i, lsu_rdata_o;
  logic ld_req_i, ld_we_i, ld_rvalid_o;
  bank_sel_t ld_bank_i;
  word_addr_t ld_addr_i;
  be_t ld_be_i;
  data_t ld_wdata_i, ld_rdata_o;
  logic ext_req_o, ext_we_o, ext_rvalid_i, ext_credit_i;
  addr_t ext_addr_o;
  be_t ext_be_o;
  data_t ext_wdata_o, ext_rdata_i;

  // Stimulus table
  string t_name[MAX_ENTRIES];
  int    t_port[MAX_ENTRIES];
  int    t_bank[MAX_ENTRIES];
  addr_t t_addr[MAX_ENTRIES];
  logic  t_we[MAX_ENTRIES];
  be_t   t_be[MAX_ENTRIES];
  data_t t_wdata[MAX_ENTRIES];
  data_t t_exp[MAX_ENTRIES];
  logic  t_chk[MAX_ENTRIES];
  int    n_entries = 0;
  int    cycles = 0;
  int    cycle_limit = 1000;
  int    seed = 32'h71a1_9c87;

  // External responder state
  addr_t rsp_addr[$];
  logic  rsp_we[$];
  be_t   rsp_be[$];
  data_t rsp_wdata[$];
  int    rsp_due[$];
  data_t ext_mem[addr_t];

  core_mem_region core_mem_region_inst (.*);
  core_mem_checker core_mem_checker_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("Timeout: run exceeded %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic add_entry(input string name, input int port, input int bank, input addr_t addr,
                           input logic we, input be_t be, input data_t wdata, input data_t exp,
                           input logic chk);
    t_name[n_entries]  = name;
    t_port[n_entries]  = port;
    t_bank[n_entries]  = bank;
    t_addr[n_entries]  = addr;
    t_we[n_entries]    = we;
    t_be[n_entries]    = be;
    t_wdata[n_entries] = wdata;
    t_exp[n_entries]   = exp;
    t_chk[n_entries]   = chk;
    n_entries++;
  endtask

  task automatic build_table();
    add_entry("ld_w_b0_a", P_LD, 0, 32'h0c, 1, 4'hf, 32'h0000_1111, 0, 0);
    add_entry("ld_w_b0_b", P_LD, 0, 32'h10, 1, 4'hf, 32'h2222_0000, 0, 0);
    add_entry("ld_w_b1_a", P_LD, 1, 32'h14, 1, 4'hf, 32'h1122_3344, 0, 0);
    add_entry("ld_w_b1_b", P_LD, 1, 32'h18, 1, 4'hf, 32'h5566_7788, 0, 0);
    add_entry("ld_r_b0", P_LD, 0, 32'h0c, 0, 4'hf, 0, 32'h0000_1111, 1);
    add_entry("ld_r_b1", P_LD, 1, 32'h14, 0, 4'hf, 0, 32'h1122_3344, 1);
    // Write returns the word it replaces
    add_entry("ld_ow_b1", P_LD, 1, 32'h18, 1, 4'hf, 32'h99aa_bbcc, 32'h5566_7788, 1);
    add_entry("ld_r_b1_new", P_LD, 1, 32'h18, 0, 4'hf, 0, 32'h99aa_bbcc, 1);
    add_entry("fetch_a", P_FETCH, 0, 32'h0c, 0, 4'hf, 0, 32'h0000_1111, 1);
    add_entry("fetch_b", P_FETCH, 0, 32'h10, 0, 4'hf, 0, 32'h2222_0000, 1);
    add_entry("lsu_pw", P_LSU, 1, 32'h0010_0014, 1, 4'b0101, 32'haabb_ccdd, 0, 0);
    add_entry("lsu_pr", P_LSU, 1, 32'h0010_0014, 0, 4'hf, 0, 32'h11bb_33dd, 1);
    add_entry("lsu_pw2", P_LSU, 1, 32'h0010_0018, 1, 4'b1000, 32'h0100_0000, 0, 0);
    add_entry("lsu_pr2", P_LSU, 1, 32'h0010_0018, 0, 4'hf, 0, 32'h01aa_bbcc, 1);
    // Three back to back writes meet the credit limit
    add_entry("ext_w0", P_LSU, 0, 32'h8000_0000, 1, 4'hf, 32'hcafe_0001, 0, 0);
    add_entry("ext_w1", P_LSU, 0, 32'h8000_0004, 1, 4'hf, 32'hcafe_0002, 0, 0);
    add_entry("ext_w2", P_LSU, 0, 32'h8000_0008, 1, 4'hf, 32'hcafe_0003, 0, 0);
    add_entry("ext_r0", P_LSU, 0, 32'h8000_0000, 0, 4'hf, 0, 32'hcafe_0001, 1);
    add_entry("ext_r1", P_LSU, 0, 32'h8000_0004, 0, 4'hf, 0, 32'hcafe_0002, 1);
    add_entry("ext_r2", P_LSU, 0, 32'h8000_0008, 0, 4'hf, 0, 32'hcafe_0003, 1);
    add_entry("win_after_ext", P_LSU, 1, 32'h0010_0014, 0, 4'hf, 0, 32'h11bb_33dd, 1);
    add_entry("ldfetch_b0", P_LDFETCH, 0, 32'h0c, 0, 4'hf, 0, 32'h0000_1111, 1);
  endtask

  task automatic drive_loader(input int i);
    ld_req_i   = 1'b1;
    ld_bank_i  = bank_sel_t'(t_bank[i]);
    ld_addr_i  = t_addr[i][9:2];
    ld_we_i    = t_we[i];
    ld_be_i    = t_be[i];
    ld_wdata_i = t_wdata[i];
  endtask

  // Holds the fetch until granted, optionally with a bank 0 loader read in the first cycle
  task automatic run_fetch(input int i, input logic ld_conflict);
    logic granted;
    logic first;
    granted = 1'b0;
    first   = 1'b1;
    fetch_req_i  = 1'b1;
    fetch_addr_i = t_addr[i];
    if (ld_conflict)
      drive_loader(i);
    while (!granted)
    begin
      @(posedge clk);
      granted = fetch_gnt_o;
      if (first && ld_conflict)
      begin
        if (granted)
          core_mem_checker_inst.protocol_error("fetch granted while the loader used bank 0");
        core_mem_checker_inst.expect_ld({t_name[i], " loader"}, t_exp[i], t_chk[i]);
      end
      if (granted)
        core_mem_checker_inst.expect_fetch(t_name[i], t_exp[i], t_chk[i]);
      #2;
      ld_req_i = 1'b0;
      first    = 1'b0;
    end
    fetch_req_i = 1'b0;
  endtask

  task automatic run_lsu(input int i);
    logic granted;
    granted     = 1'b0;
    lsu_req_i   = 1'b1;
    lsu_addr_i  = t_addr[i];
    lsu_we_i    = t_we[i];
    lsu_be_i    = t_be[i];
    lsu_wdata_i = t_wdata[i];
    while (!granted)
    begin
      @(posedge clk);
      granted = lsu_gnt_o;
      if (granted)
        core_mem_checker_inst.expect_lsu(t_name[i], t_addr[i], t_we[i], t_be[i], t_wdata[i],
                                         t_exp[i], t_chk[i]);
      #2;
    end
    lsu_req_i = 1'b0;
  endtask

  // External memory answers in order after 1 to 6 cycles
  initial
  begin : responder_b
    logic  seen;
    int    due;
    int    last_due;
    addr_t a;
    logic  we;
    be_t   be;
    data_t old;
    data_t wd;
    ext_rvalid_i = 1'b0;
    ext_credit_i = 1'b0;
    ext_rdata_i  = '0;
    last_due     = 0;
    forever
    begin
      @(posedge clk);
      seen = rst_n && ext_req_o;
      a    = ext_addr_o;
      we   = ext_we_o;
      be   = ext_be_o;
      wd   = ext_wdata_o;
      #2;
      if (seen)
      begin
        due = cycles + 1 + ($unsigned($random(seed)) % 6);
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        rsp_addr.push_back(a);
        rsp_we.push_back(we);
        rsp_be.push_back(be);
        rsp_wdata.push_back(wd);
        rsp_due.push_back(due);
      end
      ext_rvalid_i = 1'b0;
      ext_credit_i = 1'b0;
      if (rsp_due.size() > 0 && rsp_due[0] <= cycles)
      begin
        void'(rsp_due.pop_front());
        a   = rsp_addr.pop_front();
        be  = rsp_be.pop_front();
        wd  = rsp_wdata.pop_front();
        old = ext_mem.exists(a) ? ext_mem[a] : '0;
        if (rsp_we.pop_front())
        begin
          ext_mem[a] = old;
          for (int b = 0; b < 4; b++)
            if (be[b])
              ext_mem[a][8*b +: 8] = wd[8*b +: 8];
        end
        ext_rdata_i  = old;
        ext_rvalid_i = 1'b1;
        ext_credit_i = 1'b1;
      end
    end
  end

  initial
  begin
    rst_n = 1'b0;
    fetch_req_i = 1'b0;
    fetch_addr_i = '0;
    lsu_req_i = 1'b0;
    lsu_addr_i = '0;
    lsu_we_i = 1'b0;
    lsu_be_i = '0;
    lsu_wdata_i = '0;
    ld_req_i = 1'b0;
    ld_bank_i = '0;
    ld_addr_i = '0;
    ld_we_i = 1'b0;
    ld_be_i = '0;
    ld_wdata_i = '0;
    build_table();
    cycle_limit = n_entries * 12 + 100;
    repeat (16) @(posedge clk);
    #2 rst_n = 1'b1;
    for (int i = 0; i < n_entries; i++)
    begin
      case (t_port[i])
        P_LD:
        begin
          drive_loader(i);
          @(posedge clk);
          core_mem_checker_inst.expect_ld(t_name[i], t_exp[i], t_chk[i]);
          #2 ld_req_i = 1'b0;
        end
        P_FETCH:   run_fetch(i, 1'b0);
        P_LDFETCH: run_fetch(i, 1'b1);
        default:   run_lsu(i);
      endcase
    end
    while (core_mem_checker_inst.outstanding() > 0 || rsp_due.size() > 0)
      @(posedge clk);
    repeat (4) @(posedge clk);
    $display("Errors: %0d data, %0d protocol", core_mem_checker_inst.data_errs,
             core_mem_checker_inst.proto_errs);
    if (core_mem_checker_inst.data_errs == 0 && core_mem_checker_inst.proto_errs == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
core_mem_pkg.sv
req_router.sv
mem_bank.sv
resp_steer.sv
core_mem_region.sv
core_mem_checker.sv
tb_core_mem_region.sv

// ==== Bender.yml ====
package:
  name: core_mem_region

sources:
  - include_dirs:
      - .
    files:
      - core_mem_pkg.sv
      - req_router.sv
      - mem_bank.sv
      - resp_steer.sv
      - core_mem_region.sv
  - target: test
    include_dirs:
      - .
    files:
      - core_mem_checker.sv
      - tb_core_mem_region.sv
